// ==== compile.f ====
verilog/pipeCtrlPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/stallFlushCtrl.sv
verilog/pipeTop.sv
testbench/tbPipeTop.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the pipeline testbench with Verilator, run it, then judge the run from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module tbPipeTop -f compile.f -o simv > build.log 2>&1 \
    && ./obj_dir/simv | tee sim.log \
    || { echo "build or simulation failed, see build.log"; exit 1; }
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== testbench/tbPipeTop.sv ====
/*
 * Testbench for pipeTop at default parameters (mulCycles 4, handler at 8'hC0).
 * The program is random but fixed by the seed. Faults appear only from 8'h80 up
 * and always at 8'hBF, so every walk ends in the handler's self-branch loop.
 * Both memories answer combinationally and take random ready on the falling edge.
 */
module tbPipeTop;
    timeunit 1ns;
    timeprecision 100ps;

    import pipeCtrlPkg::*;

    localparam int mulCycles    = 4;
    localparam pcT handlerPc    = 8'hC0;
    localparam int retireTarget = 200;
    localparam int watchdogNs   = retireTarget * (mulCycles + 12) * 20;

    logic        clk = 1'b0;
    logic        rstN;
    logic        imemReady = 1'b0;
    instrT       imemInstr = '0;
    logic        dmemReady = 1'b0;
    logic        imemValid;
    pcT          imemPc;
    logic        dmemValid;
    dmemReqT     dmemReq;
    logic        retireValid;
    retireT      retire;
    logic        excValid;
    pcT          excPc;

    instrT       progMem[256];
    retireT      walkQ[$];          // retires and traps in program order
    dmemReqT     accQ[$];           // loads and stores in program order
    logic [31:0] rngState = 32'h04d58076;
    retireT      expRet;
    dmemReqT     expAcc;
    dmemReqT     heldReq;           // request seen stalled at the last edge
    logic        heldValid = 1'b0;
    logic        afterTrap = 1'b0;
    logic        sawFetch = 1'b0;
    int          postReset = 0;     // edges since rstN release
    int          retireCount = 0;
    int          retireErrs = 0;
    int          excErrs = 0;
    int          dmemErrs = 0;
    int          holdErrs = 0;
    int          resetErrs = 0;

    pipeTop uut (
        .clk(clk), .rstN(rstN), .imemReady(imemReady), .imemInstr(imemInstr),
        .dmemReady(dmemReady), .imemValid(imemValid), .imemPc(imemPc),
        .dmemValid(dmemValid), .dmemReq(dmemReq), .retireValid(retireValid),
        .retire(retire), .excValid(excValid), .excPc(excPc)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    task automatic buildProgram();
        logic [31:0] r;
        instrT       ins;
        int          tgt;
        for (int p = 0; p < 256; p++) begin
            r          = nextRand();
            ins.rd     = r[2:0];
            ins.rs     = r[5:3];
            ins.target = '0;
            case (r[11:8])
                4'd0:                ins.op = opNop;
                4'd5, 4'd6, 4'd7:    ins.op = opLoad;
                4'd8, 4'd9:          ins.op = opStore;
                4'd10, 4'd11:        ins.op = opMul;
                4'd12, 4'd13, 4'd14: ins.op = opBranch;
                4'd15:               ins.op = (p >= 128) ? opFault : opAlu;
                default:             ins.op = opAlu;
            endcase
            if (p >= int'(handlerPc) && ins.op inside {opBranch, opFault}) begin
                ins.op = opAlu;   // handler holds plain ops only
            end
            if (p == int'(handlerPc) + 6) begin
                ins.op     = opBranch;   // handler parks here
                ins.target = pcT'(p);
            end else if (p == int'(handlerPc) - 1) begin
                ins.op = opFault;        // last word of main region
            end else if (ins.op == opBranch) begin
                tgt        = p + 2 + int'(r[14:12]);   // forward, stays below handler
                ins.target = pcT'((tgt < int'(handlerPc)) ? tgt : int'(handlerPc) - 1);
            end
            progMem[p] = ins;
        end
    endtask

    // ISA reference: branch to target, fault to handler, else next word
    task automatic walkProgram();
        pcT      pc;
        retireT  ent;
        dmemReqT acc;
        pc = '0;
        for (int step = 0; step < 320; step++) begin
            ent.pc = pc;
            ent.op = progMem[pc].op;
            walkQ.push_back(ent);
            if (ent.op == opLoad || ent.op == opStore) begin
                acc.write = (ent.op == opStore);
                acc.addr  = pc;
                accQ.push_back(acc);
            end
            case (ent.op)
                opBranch: pc = progMem[pc].target;
                opFault:  pc = handlerPc;
                default:  pc = pc + 8'd1;
            endcase
        end
    endtask

    task automatic compareRetire();
        if (walkQ.size() == 0) begin
            retireErrs++;
            $display("A retire at %0t came after the expected sequence ran out", $time);
        end else begin
            expRet = walkQ.pop_front();
            assert (expRet.op != opFault) else begin
                retireErrs++;
                $display("Faulting instruction at pc %h retired at %0t", expRet.pc, $time);
            end
            assert (retire.pc == expRet.pc) else begin
                retireErrs++;
                $display("Error at %0t: retire.pc expected %h got %h",
                         $time, expRet.pc, retire.pc);
            end
            assert (retire.op == expRet.op) else begin
                retireErrs++;
                $display("Error at %0t: retire.op expected %0d got %0d",
                         $time, expRet.op, retire.op);
            end
            if (afterTrap) begin
                assert (retire.pc == handlerPc) else begin
                    excErrs++;
                    $display("Error at %0t: retire.pc after trap expected %h got %h",
                             $time, handlerPc, retire.pc);
                end
            end
        end
        afterTrap = 1'b0;
        retireCount++;
    endtask

    task automatic matchException();
        if (walkQ.size() == 0) begin
            excErrs++;
            $display("An exception at %0t came after the expected sequence ran out", $time);
        end else begin
            expRet = walkQ.pop_front();
            assert (expRet.op == opFault) else begin
                excErrs++;
                $display("Exception at %0t where pc %h should have retired", $time, expRet.pc);
            end
            assert (excPc == expRet.pc) else begin
                excErrs++;
                $display("Error at %0t: excPc expected %h got %h", $time, expRet.pc, excPc);
            end
        end
        afterTrap = 1'b1;
    endtask

    task automatic verifyAccess();
        if (accQ.size() == 0) begin
            dmemErrs++;
            $display("A data access at %0t has no matching load or store", $time);
        end else begin
            expAcc = accQ.pop_front();
            assert (dmemReq.addr == expAcc.addr) else begin
                dmemErrs++;
                $display("Error at %0t: dmemReq.addr expected %h got %h",
                         $time, expAcc.addr, dmemReq.addr);
            end
            assert (dmemReq.write == expAcc.write) else begin
                dmemErrs++;
                $display("Error at %0t: dmemReq.write expected %b got %b",
                         $time, expAcc.write, dmemReq.write);
            end
        end
    endtask

    // memory models, new ready and fetched word each falling edge
    always @(negedge clk) begin
        imemReady <= (nextRand() % 4) != 0;
        dmemReady <= (nextRand() % 3) != 0;
        imemInstr <= progMem[imemPc];
    end

    // values read here are the settled ones from before the edge
    always @(posedge clk) begin
        if (!rstN || postReset <= 1) begin
            assert (!retireValid && !excValid && !dmemValid) else begin
                resetErrs++;
                $display("Error at %0t: retireValid/excValid/dmemValid expected 0/0/0 got %b/%b/%b",
                         $time, retireValid, excValid, dmemValid);
            end
        end
        if (rstN) begin
            postReset++;
            if (imemValid && !sawFetch) begin
                sawFetch = 1'b1;
                assert (imemPc == 8'h00) else begin
                    resetErrs++;
                    $display("Error at %0t: imemPc expected 00 got %h", $time, imemPc);
                end
            end
            if (retireValid) begin
                compareRetire();
            end
            if (excValid) begin
                matchException();
            end
            if (dmemValid && dmemReady) begin
                verifyAccess();
            end
            if (heldValid) begin
                assert (dmemValid) else begin
                    holdErrs++;
                    $display("Error at %0t: dmemValid expected 1 got 0", $time);
                end
                assert (dmemReq == heldReq) else begin
                    holdErrs++;
                    $display("Error at %0t: dmemReq expected %h got %h", $time, heldReq, dmemReq);
                end
            end
            heldValid = dmemValid && !dmemReady;   // stalled request must hold
            heldReq   = dmemReq;
        end
    end

    initial begin
        #(watchdogNs);
        $display("Timeout: %0d of %0d instructions retired within %0d ns",
                 retireCount, retireTarget, watchdogNs);
        $display("Test failures found");
        $finish;
    end

    initial begin
        int totalErrs;
        buildProgram();
        walkProgram();
        rstN = 1'b0;
        repeat (8) @(negedge clk);
        rstN = 1'b1;
        while (retireCount < retireTarget) begin
            @(negedge clk);
        end
        totalErrs = retireErrs + excErrs + dmemErrs + holdErrs + resetErrs;
        $display("errors: retire %0d, exception %0d, dmem %0d, hold %0d, reset %0d",
                 retireErrs, excErrs, dmemErrs, holdErrs, resetErrs);
        if (totalErrs == 0 && sawFetch) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== verilog/decodeStage.sv ====
/*
 * Decode: load-use detection, branch resolution and the ID/EX register.
 * Every branch in ID is taken; fetch always guessed fall-through.
 * The hazard check compares only rs against a load's rd in EX.
 */
module decodeStage (
    input  logic               clk,
    input  logic               rstN,
    input  pipeCtrlPkg::ctrlT  ctrl,
    input  pipeCtrlPkg::stageT idStage,
    input  pipeCtrlPkg::stageT exStage,     // ID/EX output routed back by the top
    output logic               loadUse,
    output logic               branchTaken,
    output pipeCtrlPkg::pcT    branchTarget,
    output pipeCtrlPkg::stageT exStageOut
);
    import pipeCtrlPkg::*;

    logic exIsLoad;
    logic idReadsRs;

    // load still in EX, data not back until after MEM
    assign exIsLoad  = exStage.valid && (exStage.instr.op == opLoad);
    assign idReadsRs = idStage.valid && (idStage.instr.op != opNop);  // nop reads nothing

    assign loadUse = exIsLoad && idReadsRs && (exStage.instr.rd == idStage.instr.rs);

    assign branchTaken  = idStage.valid && (idStage.instr.op == opBranch);
    assign branchTarget = idStage.instr.target;

    // ID/EX register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exStageOut <= bubbleStage;
        end else if (ctrl.exWr) begin
            if (ctrl.exFlush || ctrl.exBubble) begin
                exStageOut <= bubbleStage;   // trap flush or load-use bubble
            end else begin
                exStageOut <= idStage;
            end
        end
    end

endmodule

// ==== verilog/executeStage.sv ====
/*
 * Execute: holds a multiply in EX for mulCycles cycles, then the
 * EX/MEM register. mulCycles must be at least 1.
 * The count restarts whenever ID/EX loads new content.
 */
module executeStage #(
    parameter int mulCycles = 4
) (
    input  logic               clk,
    input  logic               rstN,
    input  pipeCtrlPkg::ctrlT  ctrl,
    input  pipeCtrlPkg::stageT exStage,
    output logic               mulBusy,
    output pipeCtrlPkg::stageT memStage
);
    import pipeCtrlPkg::*;

    localparam int cntW = (mulCycles > 1) ? $clog2(mulCycles) : 1;

    logic [cntW-1:0] mulCnt;    // cycles the multiply has spent in EX
    logic            exIsMul;

    assign exIsMul = exStage.valid && (exStage.instr.op == opMul);
    // busy through cycle mulCycles-2, free to leave on the last one
    assign mulBusy = exIsMul && (int'(mulCnt) < mulCycles - 1);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mulCnt <= '0;
        end else if (ctrl.exWr) begin
            mulCnt <= '0;            // new op enters EX
        end else if (mulBusy) begin
            mulCnt <= mulCnt + 1'b1;
        end
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memStage <= bubbleStage;
        end else if (ctrl.memWr) begin
            if (ctrl.memFlush || ctrl.memBubble) begin
                memStage <= bubbleStage;   // trap flush or multiply hold
            end else begin
                memStage <= exStage;
            end
        end
    end

endmodule

// ==== verilog/fetchStage.sv ====
/*
 * PC register, instruction request port and IF/ID register.
 * Request valid is masked while the PC is held, so any accepted word
 * lands in IF/ID on the same edge. A redirect drops the pending request
 * and the next cycle asks again at the new PC.
 */
module fetchStage #(
    parameter pipeCtrlPkg::pcT handlerPc = 8'hC0
) (
    input  logic               clk,
    input  logic               rstN,
    input  pipeCtrlPkg::ctrlT  ctrl,
    input  pipeCtrlPkg::pcT    branchTarget,
    input  logic               imemReady,
    input  pipeCtrlPkg::instrT imemInstr,
    output logic               imemValid,
    output pipeCtrlPkg::pcT    imemPc,
    output logic               icacheBusy,
    output pipeCtrlPkg::stageT idStage
);
    import pipeCtrlPkg::*;

    pcT    pc;
    logic  fetchOn;    // first edge after reset turns fetch on
    logic  noRedir;
    logic  xfer;       // handshake this cycle
    pcT    pcNext;
    stageT idNext;

    assign noRedir    = (ctrl.redir == redirNone);
    assign icacheBusy = fetchOn && !imemReady;  // from the unmasked request, no loop via pcWr
    // keep valid up while waiting on ready so the PC stays presented
    assign imemValid  = fetchOn && noRedir && (ctrl.pcWr || icacheBusy);
    assign imemPc     = pc;
    assign xfer       = imemValid && imemReady;

    always_comb begin
        case (ctrl.redir)
            redirTrap:   pcNext = handlerPc;
            redirBranch: pcNext = branchTarget;
            default:     pcNext = xfer ? pc + 1'b1 : pc;  // fall-through prediction
        endcase
    end

    always_comb begin
        idNext = bubbleStage;
        if (!ctrl.idFlush && xfer) begin
            idNext.valid = 1'b1;
            idNext.pc    = pc;
            idNext.instr = imemInstr;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc      <= '0;
            fetchOn <= 1'b0;
            idStage <= bubbleStage;
        end else begin
            fetchOn <= 1'b1;
            if (ctrl.pcWr) begin
                pc <= pcNext;
            end
            if (ctrl.idWr) begin
                idStage <= idNext;   // bubble when flushed or nothing fetched
            end
        end
    end

endmodule

// ==== verilog/memoryStage.sv ====
/*
 * Memory stage: data request port, trap detection and MEM/WB.
 * A request stays up until accepted and is never withdrawn; once taken
 * it is not reissued while the stage is frozen. Load data is not modelled.
 */
module memoryStage (
    input  logic                 clk,
    input  logic                 rstN,
    input  pipeCtrlPkg::ctrlT    ctrl,
    input  pipeCtrlPkg::stageT   memStage,
    input  logic                 dmemReady,
    output logic                 dmemValid,
    output pipeCtrlPkg::dmemReqT dmemReq,
    output logic                 dcacheBusy,
    output logic                 trap,
    output logic                 retireValid,
    output pipeCtrlPkg::retireT  retire,
    output logic                 excValid,
    output pipeCtrlPkg::pcT      excPc
);
    import pipeCtrlPkg::*;

    logic memIsAccess;
    logic accessDone;   // handshake done, stage still frozen

    assign memIsAccess = memStage.valid &&
                         (memStage.instr.op == opLoad || memStage.instr.op == opStore);
    assign dmemValid   = memIsAccess && !accessDone;
    assign dmemReq     = '{write: (memStage.instr.op == opStore), addr: memStage.pc};
    assign dcacheBusy  = dmemValid && !dmemReady;
    assign trap        = memStage.valid && (memStage.instr.op == opFault);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            accessDone <= 1'b0;
        end else if (ctrl.memWr) begin
            accessDone <= 1'b0;          // EX/MEM reloads, fresh op next
        end else if (dmemValid && dmemReady) begin
            accessDone <= 1'b1;          // accepted while icache holds us
        end
    end

    // MEM/WB valids, bubble whenever the pipe is frozen
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            retireValid <= 1'b0;
            excValid    <= 1'b0;
        end else begin
            retireValid <= ctrl.memWr && memStage.valid && !trap;
            excValid    <= ctrl.memWr && trap;   // fault never retires
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.memWr) begin
            retire.pc <= memStage.pc;
            retire.op <= memStage.instr.op;
            excPc     <= memStage.pc;
        end
    end

endmodule

// ==== verilog/pipeCtrlPkg.sv ====
/*
 * Shared types for the five-stage pipeline and its stall/flush control.
 * Instructions are tokens with register numbers; no operand values travel.
 * PCs are word addresses and wrap at 2**pcW.
 */
package pipeCtrlPkg;

    localparam int pcW = 8;

    typedef logic [pcW-1:0] pcT;
    typedef logic [2:0]     regT;

    typedef enum logic [2:0] {
        opNop, opAlu, opLoad, opStore, opMul, opBranch, opFault
    } opT;

    typedef struct packed {
        opT  op;
        regT rd;
        regT rs;
        pcT  target;      // branch destination, ignored otherwise
    } instrT;

    typedef struct packed {
        logic  valid;
        pcT    pc;
        instrT instr;
    } stageT;

    typedef enum logic [1:0] {redirNone, redirBranch, redirTrap} redirT;

    // raw conditions raised by the stages
    typedef struct packed {
        logic icacheBusy;
        logic dcacheBusy;
        logic loadUse;
        logic mulBusy;
        logic branchTaken;
        logic trap;
    } hazardT;

    // per-stage enables, flushes and fetch redirect
    typedef struct packed {
        logic  pcWr;
        logic  idWr;
        logic  exWr;
        logic  memWr;      // EX/MEM and MEM/WB
        logic  idFlush;
        logic  exFlush;
        logic  memFlush;
        logic  exBubble;
        logic  memBubble;
        redirT redir;
    } ctrlT;

    typedef struct packed {
        logic write;       // 1 = store
        pcT   addr;
    } dmemReqT;

    typedef struct packed {
        pcT pc;
        opT op;
    } retireT;

    localparam stageT bubbleStage = '0;  // valid low, empty slot

endpackage

// ==== verilog/pipeTop.sv ====
/*
 * Five-stage pipeline top: four stage blocks plus the stall/flush control.
 * Both memories sit outside behind valid/ready ports.
 * Up to four instructions in flight between IF/ID and MEM/WB.
 */
module pipeTop #(
    parameter int              mulCycles = 4,
    parameter pipeCtrlPkg::pcT handlerPc = 8'hC0
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 imemReady,
    input  pipeCtrlPkg::instrT   imemInstr,
    input  logic                 dmemReady,
    output logic                 imemValid,
    output pipeCtrlPkg::pcT      imemPc,
    output logic                 dmemValid,
    output pipeCtrlPkg::dmemReqT dmemReq,
    output logic                 retireValid,
    output pipeCtrlPkg::retireT  retire,
    output logic                 excValid,
    output pipeCtrlPkg::pcT      excPc
);
    import pipeCtrlPkg::*;

    hazardT hazard;         // each field driven by one stage
    ctrlT   ctrl;
    stageT  idStage;        // IF/ID
    stageT  exStage;        // ID/EX
    stageT  memStage;       // EX/MEM
    pcT     branchTarget;

    fetchStage #(.handlerPc(handlerPc)) uFetch (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .branchTarget(branchTarget),
        .imemReady(imemReady), .imemInstr(imemInstr), .imemValid(imemValid),
        .imemPc(imemPc), .icacheBusy(hazard.icacheBusy), .idStage(idStage)
    );

    decodeStage uDecode (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .idStage(idStage), .exStage(exStage),
        .loadUse(hazard.loadUse), .branchTaken(hazard.branchTaken),
        .branchTarget(branchTarget), .exStageOut(exStage)
    );

    executeStage #(.mulCycles(mulCycles)) uExecute (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .exStage(exStage),
        .mulBusy(hazard.mulBusy), .memStage(memStage)
    );

    memoryStage uMemory (
        .clk(clk), .rstN(rstN), .ctrl(ctrl), .memStage(memStage),
        .dmemReady(dmemReady), .dmemValid(dmemValid), .dmemReq(dmemReq),
        .dcacheBusy(hazard.dcacheBusy), .trap(hazard.trap),
        .retireValid(retireValid), .retire(retire), .excValid(excValid), .excPc(excPc)
    );

    stallFlushCtrl uCtrl (
        .hazard(hazard),
        .ctrl(ctrl)
    );

endmodule

// ==== verilog/stallFlushCtrl.sv ====
/*
 * Stall/flush priority for the five-stage pipeline, purely combinational.
 * Order: trap, busy cache, load-use, taken branch, busy multiply.
 * A taken branch waits in ID while a multiply still holds EX, so the
 * branch is never flushed out of IF/ID before it can move on.
 */
module stallFlushCtrl (
    input  pipeCtrlPkg::hazardT hazard,
    output pipeCtrlPkg::ctrlT   ctrl
);
    import pipeCtrlPkg::*;

    logic cacheBusy;
    logic branchGo;

    assign cacheBusy = hazard.icacheBusy || hazard.dcacheBusy;
    assign branchGo  = hazard.branchTaken && !hazard.mulBusy;  // EX must be free

    always_comb begin
        // default: everything advances
        ctrl.pcWr      = 1'b1;
        ctrl.idWr      = 1'b1;
        ctrl.exWr      = 1'b1;
        ctrl.memWr     = 1'b1;
        ctrl.idFlush   = 1'b0;
        ctrl.exFlush   = 1'b0;
        ctrl.memFlush  = 1'b0;
        ctrl.exBubble  = 1'b0;
        ctrl.memBubble = 1'b0;
        ctrl.redir     = redirNone;

        if (hazard.trap) begin
            // faulting op moves to WB as exception, younger ops die
            ctrl.idFlush  = 1'b1;
            ctrl.exFlush  = 1'b1;
            ctrl.memFlush = 1'b1;
            ctrl.redir    = redirTrap;
        end else if (cacheBusy) begin
            ctrl.pcWr  = 1'b0;   // full freeze
            ctrl.idWr  = 1'b0;
            ctrl.exWr  = 1'b0;
            ctrl.memWr = 1'b0;   // MEM/WB sees a bubble
        end else if (hazard.loadUse) begin
            ctrl.pcWr     = 1'b0;
            ctrl.idWr     = 1'b0;
            ctrl.exBubble = 1'b1;   // load moves on, consumer waits in ID
        end else if (branchGo) begin
            ctrl.idFlush = 1'b1;    // squash the fall-through fetch
            ctrl.redir   = redirBranch;
        end else if (hazard.mulBusy) begin
            ctrl.pcWr      = 1'b0;
            ctrl.idWr      = 1'b0;
            ctrl.exWr      = 1'b0;
            ctrl.memBubble = 1'b1;  // older ops drain past the multiply
        end
    end

endmodule
